// File: include/trace_defines.svh
// Trace buffer build constants and software register map
// Shared by the RTL and the testbench

`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// Record buffer depth, must stay a power of two
`define TRACE_FIFO_DEPTH 8
`define TRACE_XLEN       32
`define TRACE_REG_AW     8

// AXI4-Lite register offsets
`define REG_CTRL      8'h00
`define REG_OPC_MASK  8'h04
`define REG_STATUS    8'h08
`define REG_DROPS     8'h0C
`define REG_POP_PC    8'h10
`define REG_POP_INSTR 8'h14
`define REG_POP_WB    8'h18
`define REG_POP       8'h1C

`endif

// File: hw/trace_pkg.sv
// Retire trace types
// Captured record layout and the two decode views of an instruction word

`include "trace_defines.svh"

package trace_pkg;

    // One retired instruction as stored in the trace buffer
    typedef struct packed {
        logic [`TRACE_XLEN-1:0] pc;
        logic [`TRACE_XLEN-1:0] instr;
        logic [4:0]             rd_addr;
        logic                   rd_we;
    } retire_rec_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_i_t;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

endpackage

// File: hw/trace_stream_if.sv
// Record stream from the trace filter into the trace FIFO
// Write when valid and not full, a record offered while full is lost

`timescale 1ns/1ps
`include "trace_defines.svh"

interface trace_stream_if
    import trace_pkg::*;
();

    logic                   valid;
    logic                   full;
    retire_rec_t            rec;
    logic [`TRACE_XLEN-1:0] wdata;   // Write-back data beside the record

    modport src (
        output valid, rec, wdata,
        input  full
    );

    modport snk (
        input  valid, rec, wdata,
        output full
    );

endinterface

// File: hw/trace_filter.sv
// Retire trace filter
// Registers retire events, applies opcode mask and ebreak stop, counts lost records

`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_filter
    import trace_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   retire_valid_i,
    input  logic [`TRACE_XLEN-1:0] pc_i,
    input  logic [`TRACE_XLEN-1:0] instr_i,
    input  logic                   illegal_i,
    input  logic [4:0]             rd_addr_i,
    input  logic                   rd_we_i,
    input  logic [`TRACE_XLEN-1:0] rd_wdata_i,
    input  logic                   capture_en_i,
    input  logic                   stop_on_ebreak_i,
    input  logic [31:0]            opc_mask_i,
    input  logic                   clear_i,
    output logic                   halted_o,
    output logic [15:0]            drops_o,
    trace_stream_if.src            out
);

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic                   ret_valid_q;
    logic                   illegal_q;
    logic [`TRACE_XLEN-1:0] pc_q;
    insn_u                  insn_q;
    logic [4:0]             rd_addr_q;
    logic                   rd_we_q;
    logic [`TRACE_XLEN-1:0] rd_wdata_q;
    logic                   halted_q;
    logic [15:0]            drops_q;
    logic                   keep;
    logic                   is_ebreak;

    // First stage samples the core signals as presented
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= retire_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q       <= pc_i;
        insn_q     <= instr_i;
        illegal_q  <= illegal_i;
        rd_addr_q  <= rd_addr_i;
        rd_we_q    <= rd_we_i;
        rd_wdata_q <= rd_wdata_i;
    end

    // Mask is indexed by opcode[6:2]
    assign keep = ret_valid_q && capture_en_i && !halted_q && !illegal_q
                  && opc_mask_i[insn_q.r.opcode[6:2]];

    assign is_ebreak = (insn_q.i.opcode == OPC_SYSTEM) && (insn_q.i.funct3 == 3'b000)
                       && (insn_q.i.imm12 == 12'h001);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out.valid <= 1'b0;
            halted_q  <= 1'b0;
            drops_q   <= '0;
        end else begin
            out.valid <= keep;
            if (clear_i) begin
                halted_q <= 1'b0;
            end else if (keep && stop_on_ebreak_i && is_ebreak) begin
                halted_q <= 1'b1;   // Ebreak itself still goes out
            end
            if (clear_i) begin
                drops_q <= '0;
            end else if (out.valid && out.full && (drops_q != '1)) begin
                drops_q <= drops_q + 16'd1;   // Saturating
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep) begin
            out.rec   <= '{pc: pc_q, instr: insn_q, rd_addr: rd_addr_q, rd_we: rd_we_q};
            out.wdata <= rd_wdata_q;
        end
    end

    assign halted_o = halted_q;
    assign drops_o  = drops_q;

    // Once halted nothing new leaves the filter until software clears it
    a_no_valid_halted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (halted_q && !clear_i) |=> !out.valid);

endmodule

// File: hw/trace_fifo.sv
// Trace record FIFO
// Circular buffer with wrap-bit pointers, head is visible without popping

`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_fifo
    import trace_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    trace_stream_if.snk            in,
    input  logic                   pop_i,
    output retire_rec_t            head_rec_o,
    output logic [`TRACE_XLEN-1:0] head_wdata_o,
    output logic [4:0]             level_o
);

    localparam int AW = $clog2(`TRACE_FIFO_DEPTH);

    retire_rec_t            rec_mem   [`TRACE_FIFO_DEPTH];
    logic [`TRACE_XLEN-1:0] wdata_mem [`TRACE_FIFO_DEPTH];
    logic [AW:0]            wptr_q;
    logic [AW:0]            rptr_q;
    logic                   empty;
    logic                   push;
    logic                   pop;

    // Same index, different wrap bit
    assign in.full = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);
    assign empty   = (wptr_q == rptr_q);
    assign push    = in.valid && !in.full;
    assign pop     = pop_i && !empty;   // Pop on empty is ignored

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr_q <= '0;
            rptr_q <= '0;
        end else begin
            if (push) wptr_q <= wptr_q + 1'b1;
            if (pop)  rptr_q <= rptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            rec_mem[wptr_q[AW-1:0]]   <= in.rec;
            wdata_mem[wptr_q[AW-1:0]] <= in.wdata;
        end
    end

    assign head_rec_o   = rec_mem[rptr_q[AW-1:0]];
    assign head_wdata_o = wdata_mem[rptr_q[AW-1:0]];
    assign level_o      = 5'({wptr_q - rptr_q});

    a_level_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        level_o <= 5'(`TRACE_FIFO_DEPTH));

    // Write side must not advance while the buffer is full
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (level_o == 5'(`TRACE_FIFO_DEPTH)) |=> $stable(wptr_q));

endmodule

// File: hw/trace_regs.sv
// Trace register block
// AXI4-Lite slave for control, opcode mask, status and the FIFO read window

`timescale 1ns/1ps
`include "trace_defines.svh"

module trace_regs
    import trace_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [`TRACE_REG_AW-1:0] awaddr_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  logic [31:0]              wdata_i,
    input  logic [3:0]               wstrb_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    output logic [1:0]               bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i,
    input  logic [`TRACE_REG_AW-1:0] araddr_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,
    output logic [31:0]              rdata_o,
    output logic [1:0]               rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i,
    output logic                     capture_en_o,
    output logic                     stop_on_ebreak_o,
    output logic [31:0]              opc_mask_o,
    output logic                     clear_o,
    output logic                     pop_o,
    input  logic                     halted_i,
    input  logic [15:0]              drops_i,
    input  retire_rec_t              head_rec_i,
    input  logic [`TRACE_XLEN-1:0]   head_wdata_i,
    input  logic [4:0]               level_i
);

    logic        wr_hs;
    logic        rd_hs;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  ctrl_q;     // [0] capture enable, [1] stop on ebreak
    logic [31:0] mask_q;
    logic        fifo_empty;
    logic [31:0] rd_mux;

    // Address and data are taken together, only with no response pending
    assign wr_hs     = awvalid_i && wvalid_i && !bvalid_q;
    assign awready_o = wr_hs;
    assign wready_o  = wr_hs;
    assign bvalid_o  = bvalid_q;
    assign bresp_o   = 2'b00;

    assign arready_o = !rvalid_q;
    assign rd_hs     = arvalid_i && !rvalid_q;
    assign rvalid_o  = rvalid_q;
    assign rdata_o   = rdata_q;
    assign rresp_o   = 2'b00;

    assign capture_en_o     = ctrl_q[0];
    assign stop_on_ebreak_o = ctrl_q[1];
    assign opc_mask_o       = mask_q;

    // Side-effect strobes act on the write handshake edge
    assign clear_o    = wr_hs && (awaddr_i == `REG_STATUS);
    assign pop_o      = wr_hs && (awaddr_i == `REG_POP);
    assign fifo_empty = (level_i == 5'd0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
            mask_q <= '1;    // All opcode groups traced by default
        end else if (wr_hs) begin
            case (awaddr_i)
                `REG_CTRL: begin
                    if (wstrb_i[0]) ctrl_q <= wdata_i[1:0];
                end
                `REG_OPC_MASK: begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb_i[b]) mask_q[8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
                default: ;   // Unknown offsets accepted and ignored
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Pop window reads zero when the FIFO is empty
    always_comb begin
        case (araddr_i)
            `REG_CTRL:      rd_mux = {30'b0, ctrl_q};
            `REG_OPC_MASK:  rd_mux = mask_q;
            `REG_STATUS:    rd_mux = {22'b0, (drops_i != 16'd0), halted_i, 3'b0, level_i};
            `REG_DROPS:     rd_mux = {16'b0, drops_i};
            `REG_POP_PC:    rd_mux = fifo_empty ? 32'b0 : head_rec_i.pc;
            `REG_POP_INSTR: rd_mux = fifo_empty ? 32'b0 : head_rec_i.instr;
            `REG_POP_WB:    rd_mux = fifo_empty ? 32'b0 : head_wdata_i;
            `REG_POP: begin
                // Head destination register and write enable
                rd_mux = fifo_empty ? 32'b0 : {26'b0, head_rec_i.rd_we, head_rec_i.rd_addr};
            end
            default:        rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_hs) rdata_q <= rd_mux;
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (bvalid_q && !bready_i) |=> bvalid_q);

    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rvalid_q && !rready_i) |=> (rvalid_q && $stable(rdata_q)));

endmodule

// File: hw/core_trace_wrapper.sv
// Core trace wrapper
// Retire observation in, filtered records buffered and read over AXI4-Lite

`timescale 1ns/1ps
`include "trace_defines.svh"

module core_trace_wrapper
    import trace_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Core retire observation
    input  logic                     retire_valid_i,
    input  logic [`TRACE_XLEN-1:0]   pc_i,
    input  logic [`TRACE_XLEN-1:0]   instr_i,
    input  logic                     illegal_i,
    input  logic [4:0]               rd_addr_i,
    input  logic                     rd_we_i,
    input  logic [`TRACE_XLEN-1:0]   rd_wdata_i,
    // AXI4-Lite slave
    input  logic [`TRACE_REG_AW-1:0] awaddr_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  logic [31:0]              wdata_i,
    input  logic [3:0]               wstrb_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    output logic [1:0]               bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i,
    input  logic [`TRACE_REG_AW-1:0] araddr_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,
    output logic [31:0]              rdata_o,
    output logic [1:0]               rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i
);

    logic                   capture_en;
    logic                   stop_on_ebreak;
    logic [31:0]            opc_mask;
    logic                   clear;
    logic                   pop;
    logic                   halted;
    logic [15:0]            drops;
    retire_rec_t            head_rec;
    logic [`TRACE_XLEN-1:0] head_wdata;
    logic [4:0]             level;

    trace_stream_if stream_if ();

    trace_filter filter_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .retire_valid_i   (retire_valid_i),
        .pc_i             (pc_i),
        .instr_i          (instr_i),
        .illegal_i        (illegal_i),
        .rd_addr_i        (rd_addr_i),
        .rd_we_i          (rd_we_i),
        .rd_wdata_i       (rd_wdata_i),
        .capture_en_i     (capture_en),
        .stop_on_ebreak_i (stop_on_ebreak),
        .opc_mask_i       (opc_mask),
        .clear_i          (clear),
        .halted_o         (halted),
        .drops_o          (drops),
        .out              (stream_if.src)
    );

    trace_fifo fifo_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in           (stream_if.snk),
        .pop_i        (pop),
        .head_rec_o   (head_rec),
        .head_wdata_o (head_wdata),
        .level_o      (level)
    );

    trace_regs regs_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .awaddr_i         (awaddr_i),
        .awvalid_i        (awvalid_i),
        .awready_o        (awready_o),
        .wdata_i          (wdata_i),
        .wstrb_i          (wstrb_i),
        .wvalid_i         (wvalid_i),
        .wready_o         (wready_o),
        .bresp_o          (bresp_o),
        .bvalid_o         (bvalid_o),
        .bready_i         (bready_i),
        .araddr_i         (araddr_i),
        .arvalid_i        (arvalid_i),
        .arready_o        (arready_o),
        .rdata_o          (rdata_o),
        .rresp_o          (rresp_o),
        .rvalid_o         (rvalid_o),
        .rready_i         (rready_i),
        .capture_en_o     (capture_en),
        .stop_on_ebreak_o (stop_on_ebreak),
        .opc_mask_o       (opc_mask),
        .clear_o          (clear),
        .pop_o            (pop),
        .halted_i         (halted),
        .drops_i          (drops),
        .head_rec_i       (head_rec),
        .head_wdata_i     (head_wdata),
        .level_i          (level)
    );

endmodule

// File: verif/tb_core_trace.sv
// Core trace wrapper testbench
// Random retire streams checked against a queue model through the AXI4-Lite pop window

`timescale 1ns/1ps
`include "trace_defines.svh"

module tb_core_trace
    import trace_pkg::*;
();

    localparam int AXI_OPS     = 500;   // Rough upper count of register accesses
    localparam int TEST_CYCLES = AXI_OPS * 5 + 300;
    localparam int HS_LIMIT    = 20;

    logic                     clk_i;
    logic                     arst_n_i;
    logic                     retire_valid_i;
    logic [31:0]              pc_i;
    logic [31:0]              instr_i;
    logic                     illegal_i;
    logic [4:0]               rd_addr_i;
    logic                     rd_we_i;
    logic [31:0]              rd_wdata_i;
    logic [`TRACE_REG_AW-1:0] awaddr_i;
    logic                     awvalid_i;
    logic                     awready_o;
    logic [31:0]              wdata_i;
    logic [3:0]               wstrb_i;
    logic                     wvalid_i;
    logic                     wready_o;
    logic [1:0]               bresp_o;
    logic                     bvalid_o;
    logic                     bready_i;
    logic [`TRACE_REG_AW-1:0] araddr_i;
    logic                     arvalid_i;
    logic                     arready_o;
    logic [31:0]              rdata_o;
    logic [1:0]               rresp_o;
    logic                     rvalid_o;
    logic                     rready_i;

    // Reference model state
    logic [31:0] q_pc[$];
    logic [31:0] q_instr[$];
    logic [31:0] q_wb[$];
    logic [31:0] q_rd[$];
    logic        m_capture = 1'b0;
    logic        m_stop    = 1'b0;
    logic [31:0] m_mask    = '1;
    logic        m_halted  = 1'b0;
    logic [15:0] m_drops   = '0;

    logic [31:0] lfsr = 32'hbbd8;
    string       test_name;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0 = 0;

    core_trace_wrapper dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (TEST_CYCLES * 4 + 200) @(posedge clk_i);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] random_instr();
        return rand_bits(32) | 32'h3;   // 32-bit encoding space
    endfunction

    function automatic logic is_ebreak(input logic [31:0] w);
        return (w[6:0] == 7'h73) && (w[14:12] == 3'b000) && (w[31:20] == 12'h001);
    endfunction

    function automatic logic [31:0] status_exp();
        logic [4:0] lvl;
        lvl = 5'(q_pc.size());
        return {22'b0, (m_drops != 16'd0), m_halted, 3'b0, lvl};
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic axi_write(input logic [`TRACE_REG_AW-1:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk_i);
        awaddr_i  <= addr;
        wdata_i   <= data;
        wstrb_i   <= 4'hf;
        awvalid_i <= 1'b1;
        wvalid_i  <= 1'b1;
        do begin
            @(negedge clk_i);
            n++;
        end while (!(awready_o && wready_o) && n < HS_LIMIT);
        if (!(awready_o && wready_o)) begin
            errors++;
            $display("write to offset %h was never accepted", addr);
        end
        @(posedge clk_i);               // Handshake edge
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!bvalid_o && n < HS_LIMIT);
        if (!bvalid_o) begin
            errors++;
            $display("no write response for offset %h", addr);
        end
        check("bresp", 32'd0, {30'b0, bresp_o});   // OKAY
    endtask

    task automatic axi_read(input logic [`TRACE_REG_AW-1:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk_i);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        do begin
            @(negedge clk_i);
            n++;
        end while (!arready_o && n < HS_LIMIT);
        @(posedge clk_i);
        arvalid_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!rvalid_o && n < HS_LIMIT);
        if (!rvalid_o) begin
            errors++;
            $display("read of offset %h returned no data", addr);
        end
        check("rresp", 32'd0, {30'b0, rresp_o});
        data = rdata_o;
    endtask

    task automatic set_ctrl(input logic cap, input logic stop);
        axi_write(`REG_CTRL, {30'b0, stop, cap});
        m_capture = cap;
        m_stop    = stop;
    endtask

    task automatic set_mask(input logic [31:0] m);
        axi_write(`REG_OPC_MASK, m);
        m_mask = m;
    endtask

    task automatic clear_status();
        axi_write(`REG_STATUS, rand_bits(32));   // Any value clears
        m_halted = 1'b0;
        m_drops  = '0;
    endtask

    // Drive one retire event and apply the filter rules to the model
    task automatic retire_one(input logic [31:0] instr, input logic ill);
        logic [31:0] pc;
        logic [31:0] r;
        logic [31:0] wb;
        logic [4:0]  rd;
        logic        we;
        logic        kept;
        pc = rand_bits(30) << 2;
        r  = rand_bits(6);
        rd = r[4:0];
        we = r[5];
        wb = rand_bits(32);
        @(posedge clk_i);
        retire_valid_i <= 1'b1;
        pc_i           <= pc;
        instr_i        <= instr;
        illegal_i      <= ill;
        rd_addr_i      <= rd;
        rd_we_i        <= we;
        rd_wdata_i     <= wb;
        kept = m_capture && !m_halted && !ill && m_mask[instr[6:2]];
        if (kept) begin
            if (q_pc.size() < `TRACE_FIFO_DEPTH) begin
                q_pc.push_back(pc);
                q_instr.push_back(instr);
                q_wb.push_back(wb);
                q_rd.push_back({26'b0, we, rd});
            end else if (m_drops != 16'hffff) begin
                m_drops++;
            end
            if (m_stop && is_ebreak(instr)) m_halted = 1'b1;
        end
    endtask

    // Retire port idle long enough for the last record to land in the FIFO
    task automatic settle();
        @(posedge clk_i);
        retire_valid_i <= 1'b0;
        repeat (3) @(posedge clk_i);
    endtask

    task automatic run_burst(input int len, input logic allow_illegal);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = rand_bits(3);
            retire_one(random_instr(), allow_illegal && r[0]);
            if (r[2:1] == 2'b00) begin
                @(posedge clk_i);
                retire_valid_i <= 1'b0;   // Gap in the retire stream
            end
        end
        settle();
    endtask

    // Pop every record and compare with the model in order
    task automatic drain();
        logic [31:0] v;
        while (q_pc.size() > 0) begin
            axi_read(`REG_POP_PC, v);
            check("pop pc", q_pc[0], v);
            axi_read(`REG_POP_INSTR, v);
            check("pop instr", q_instr[0], v);
            check("mask bit of popped group", 32'd1, {31'b0, m_mask[v[6:2]]});
            axi_read(`REG_POP_WB, v);
            check("pop wdata", q_wb[0], v);
            axi_read(`REG_POP, v);
            check("pop rd", q_rd[0], v);
            axi_write(`REG_POP, 32'd0);
            void'(q_pc.pop_front());
            void'(q_instr.pop_front());
            void'(q_wb.pop_front());
            void'(q_rd.pop_front());
        end
        axi_read(`REG_STATUS, v);
        check("status after drain", status_exp(), v);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - test_err0);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    task automatic reset_values();
        logic [31:0] v;
        start_test("reset_values");
        axi_read(`REG_CTRL, v);
        check("ctrl", 32'h0, v);
        axi_read(`REG_OPC_MASK, v);
        check("opc mask", 32'hffff_ffff, v);
        axi_read(`REG_STATUS, v);
        check("status", 32'h0, v);
        axi_read(`REG_DROPS, v);
        check("drops", 32'h0, v);
        finish_test();
    endtask

    task automatic masked_capture();
        logic [31:0] v;
        logic [31:0] r;
        start_test("masked_capture");
        set_ctrl(1'b1, 1'b0);
        set_mask(rand_bits(32));
        axi_read(`REG_OPC_MASK, v);
        check("opc mask readback", m_mask, v);
        for (int b = 0; b < 4; b++) begin
            r = rand_bits(3);
            run_burst(2 + int'(r % 5), 1'b0);
            drain();
        end
        finish_test();
    endtask

    task automatic illegal_filtering();
        start_test("illegal_filtering");
        set_mask('1);
        for (int b = 0; b < 3; b++) begin
            run_burst(6, 1'b1);
            drain();
        end
        finish_test();
    endtask

    task automatic overflow_and_clear();
        logic [31:0] v;
        logic [31:0] r;
        int          excess;
        start_test("overflow_and_clear");
        r      = rand_bits(3);
        excess = 1 + int'(r % 5);
        run_burst(`TRACE_FIFO_DEPTH + excess, 1'b0);
        axi_read(`REG_STATUS, v);
        check("status", status_exp(), v);
        check("level", 32'd8, {27'b0, v[4:0]});
        check("overflow seen", 32'd1, {31'b0, v[9]});
        axi_read(`REG_DROPS, v);
        check("drops", excess, v);
        clear_status();
        axi_read(`REG_DROPS, v);
        check("drops after clear", 32'd0, v);
        axi_read(`REG_STATUS, v);
        check("status after clear", status_exp(), v);
        check("overflow after clear", 32'd0, {31'b0, v[9]});
        drain();
        finish_test();
    endtask

    task automatic ebreak_stop();
        logic [31:0] v;
        start_test("ebreak_stop");
        set_ctrl(1'b1, 1'b1);
        for (int i = 0; i < 3; i++) retire_one(random_instr(), 1'b0);
        retire_one(32'h0010_0073, 1'b0);
        for (int i = 0; i < 3; i++) retire_one(random_instr(), 1'b0);   // Ignored
        settle();
        axi_read(`REG_STATUS, v);
        check("status halted", status_exp(), v);
        check("halted", 32'd1, {31'b0, v[8]});
        drain();
        clear_status();
        for (int i = 0; i < 3; i++) retire_one(random_instr(), 1'b0);
        settle();
        axi_read(`REG_STATUS, v);
        check("status resumed", status_exp(), v);
        drain();
        set_ctrl(1'b1, 1'b0);
        finish_test();
    endtask

    task automatic empty_window();
        logic [31:0] v;
        start_test("empty_window");
        axi_read(`REG_POP_PC, v);
        check("empty pc", 32'd0, v);
        axi_read(`REG_POP_INSTR, v);
        check("empty instr", 32'd0, v);
        axi_read(`REG_POP_WB, v);
        check("empty wdata", 32'd0, v);
        axi_write(`REG_POP, 32'd0);
        axi_read(`REG_STATUS, v);
        check("status after empty pop", status_exp(), v);
        check("level", 32'd0, {27'b0, v[4:0]});
        finish_test();
    endtask

    initial begin
        arst_n_i       <= 1'b0;
        retire_valid_i <= 1'b0;
        pc_i           <= '0;
        instr_i        <= '0;
        illegal_i      <= 1'b0;
        rd_addr_i      <= '0;
        rd_we_i        <= 1'b0;
        rd_wdata_i     <= '0;
        awaddr_i       <= '0;
        awvalid_i      <= 1'b0;
        wdata_i        <= '0;
        wstrb_i        <= '0;
        wvalid_i       <= 1'b0;
        bready_i       <= 1'b1;
        araddr_i       <= '0;
        arvalid_i      <= 1'b0;
        rready_i       <= 1'b1;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        reset_values();
        masked_capture();
        illegal_filtering();
        overflow_and_clear();
        ebreak_stop();
        empty_window();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
hw/trace_pkg.sv
hw/trace_stream_if.sv
hw/trace_filter.sv
hw/trace_fifo.sv
hw/trace_regs.sv
hw/core_trace_wrapper.sv
verif/tb_core_trace.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the trace testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_core_trace \
    -o sim_tb && out="$(./obj_dir/sim_tb)" || { echo "build or run failed"; exit 1; }

echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
